// File: design/game_defs.svh
`ifndef GAME_DEFS_SVH
`define GAME_DEFS_SVH

// Table sizes
`define ENEMY_SLOTS   8
`define BULLET_SLOTS  32

// Radial distances
`define SPAWN_DIST    240            // Enemies appear at the rim
`define BULLET_LIMIT  240            // Bullets at or past this are dropped

// Spawn, fire and enemy move followed by one cycle per bullet
`define SWEEP_CYCLES  35

// Non-zero start value of the spawn LFSR
`define LFSR_SEED     16'hACE1

`endif

// File: design/game_pkg.sv
`default_nettype none

package game_pkg;

	typedef logic [3:0]  angle_t;    // 22.5 degree steps
	typedef logic [7:0]  dist_t;     // Distance from the turret
	typedef logic [16:0] score_t;

	typedef logic [4:0][3:0] bcd_digits_t; // Digit 0 is the least significant

	typedef enum logic [1:0] {
		WPN_SPREAD = 2'd0,
		WPN_TRIPLE = 2'd1,
		WPN_HEAVY  = 2'd2
	} weapon_t;

	typedef enum logic [2:0] {
		KIND_0 = 3'd0,
		KIND_1 = 3'd1,
		KIND_2 = 3'd2,
		KIND_3 = 3'd3,
		KIND_4 = 3'd4
	} enemy_kind_t;

	function automatic logic [3:0] enemy_health(enemy_kind_t kind);
		case (kind)
			KIND_0:  return 4'd6;
			KIND_1:  return 4'd3;
			KIND_2:  return 4'd2;
			KIND_3:  return 4'd9;
			default: return 4'd15;
		endcase
	endfunction

	function automatic dist_t enemy_speed(enemy_kind_t kind);
		case (kind)
			KIND_0:  return 8'd3;
			KIND_1:  return 8'd4;
			KIND_2:  return 8'd5;
			KIND_3:  return 8'd2;
			default: return 8'd1;
		endcase
	endfunction

	// Below this distance the enemy has reached the ship and leaves
	function automatic dist_t enemy_expiry(enemy_kind_t kind);
		case (kind)
			KIND_0:  return 8'd15;
			KIND_1:  return 8'd8;
			KIND_2:  return 8'd8;
			KIND_3:  return 8'd42;
			default: return 8'd46;
		endcase
	endfunction

	function automatic logic [3:0] kill_points(enemy_kind_t kind);
		case (kind)
			KIND_0:  return 4'd6;
			KIND_1:  return 4'd3;
			KIND_2:  return 4'd2;
			KIND_3:  return 4'd9;
			default: return 4'd5;
		endcase
	endfunction

	function automatic dist_t bullet_speed(weapon_t wpn);
		case (wpn)
			WPN_SPREAD: return 8'd7;
			WPN_TRIPLE: return 8'd5;
			default:    return 8'd4;
		endcase
	endfunction

	function automatic logic [3:0] bullet_damage(weapon_t wpn);
		case (wpn)
			WPN_SPREAD: return 4'd2;
			WPN_TRIPLE: return 4'd3;
			default:    return 4'd9;
		endcase
	endfunction

	function automatic logic [2:0] fan_size(weapon_t wpn);
		case (wpn)
			WPN_SPREAD: return 3'd5;
			WPN_TRIPLE: return 3'd3;
			default:    return 3'd1;
		endcase
	endfunction

endpackage

`default_nettype wire

// File: design/game_control.sv
`timescale 1ns/100ps
`default_nettype none
`include "game_defs.svh"

module game_control import game_pkg::*; (
	input  logic   CLK,
	input  logic   RESET,
	input  logic   game_tick,                         // One-cycle step strobe
	input  logic   weapon_switch,                     // Active-low buttons
	input  logic   fire,
	input  logic   rotate_cw,
	input  logic   rotate_ccw,
	output angle_t ship_angle,
	output weapon_t weapon,
	output logic   busy,
	output logic   spawn_en,
	output logic   fire_en,
	output logic   enemy_step,
	output logic   sweep_en,
	output logic [$clog2(`BULLET_SLOTS) - 1:0] bullet_index
);

	localparam int BTN_CCW = 0;
	localparam int BTN_CW  = 1;
	localparam int BTN_FIRE = 2;
	localparam int BTN_WPN = 3;

	localparam int STEP_W = $clog2(`SWEEP_CYCLES);
	localparam logic [STEP_W - 1:0] STEP_SPAWN = 0;
	localparam logic [STEP_W - 1:0] STEP_FIRE  = 1;
	localparam logic [STEP_W - 1:0] STEP_ENEMY = 2;
	localparam logic [STEP_W - 1:0] STEP_SWEEP = 3;   // First bullet cycle
	localparam logic [STEP_W - 1:0] STEP_LAST  = STEP_W'(`SWEEP_CYCLES - 1);

	logic [3:0] btn_pins;
	logic [3:0] sync_a;
	logic [3:0] sync_b;
	logic [3:0] sync_prev;
	logic [3:0] btn_fall;
	logic       fire_pending;
	logic [STEP_W - 1:0] step;
	logic [STEP_W - 1:0] sweep_pos;

	assign btn_pins = {weapon_switch, fire, rotate_cw, rotate_ccw};

	// Two-flop synchronizer plus one stage for edge detection
	always_ff @(posedge CLK) begin
		if (RESET) begin
			sync_a    <= '1;                             // Buttons idle high
			sync_b    <= '1;
			sync_prev <= '1;
		end else begin
			sync_a    <= btn_pins;
			sync_b    <= sync_a;
			sync_prev <= sync_b;
		end
	end

	assign btn_fall = sync_prev & ~sync_b;

	// CW counts the turret direction down
	always_ff @(posedge CLK) begin
		if (RESET)
			ship_angle <= '0;
		else
			ship_angle <= ship_angle + angle_t'(btn_fall[BTN_CCW])
				- angle_t'(btn_fall[BTN_CW]);
	end

	always_ff @(posedge CLK) begin
		if (RESET) begin
			weapon <= WPN_SPREAD;
		end else if (btn_fall[BTN_WPN]) begin
			case (weapon)
				WPN_SPREAD: weapon <= WPN_TRIPLE;
				WPN_TRIPLE: weapon <= WPN_HEAVY;
				default:    weapon <= WPN_SPREAD;
			endcase
		end
	end

	// A new press wins over the consuming tick
	always_ff @(posedge CLK) begin
		if (RESET)
			fire_pending <= 1'b0;
		else
			fire_pending <= (fire_pending & ~fire_en) | btn_fall[BTN_FIRE];
	end

	// Ticks during a running step are dropped
	always_ff @(posedge CLK) begin
		if (RESET) begin
			busy <= 1'b0;
			step <= '0;
		end else if (!busy) begin
			if (game_tick) begin
				busy <= 1'b1;
				step <= STEP_SPAWN;
			end
		end else begin
			step <= step + 1'b1;
			if (step == STEP_LAST)
				busy <= 1'b0;
		end
	end

	assign spawn_en   = busy & (step == STEP_SPAWN);
	assign fire_en    = busy & (step == STEP_FIRE) & fire_pending;
	assign enemy_step = busy & (step == STEP_ENEMY);
	assign sweep_en   = busy & (step >= STEP_SWEEP);

	assign sweep_pos    = step - STEP_SWEEP;
	assign bullet_index = sweep_pos[$clog2(`BULLET_SLOTS) - 1:0];

endmodule

`default_nettype wire

// File: design/enemy_table.sv
`timescale 1ns/100ps
`default_nettype none
`include "game_defs.svh"

module enemy_table import game_pkg::*; (
	input  logic        CLK,
	input  logic        RESET,
	input  logic        game_tick,
	input  logic        spawn_en,
	input  logic        enemy_step,
	input  logic        probe_valid,                // Bullet under test this cycle
	input  angle_t      probe_angle,
	input  dist_t       probe_dist,
	input  logic [3:0]  hit_damage,
	output logic        hit,
	output logic        kill,
	output enemy_kind_t kill_kind,
	output logic [$clog2(`ENEMY_SLOTS + 1) - 1:0] enemy_count
);

	localparam int IW = $clog2(`ENEMY_SLOTS);

	logic [15:0]       lfsr;
	logic [3:0]        kind_mod;
	enemy_kind_t       spawn_kind;
	logic [`ENEMY_SLOTS - 1:0] active;
	enemy_kind_t       slot_kind   [`ENEMY_SLOTS];
	angle_t            slot_angle  [`ENEMY_SLOTS];
	dist_t             slot_dist   [`ENEMY_SLOTS];
	logic [3:0]        slot_health [`ENEMY_SLOTS];
	logic              free_found;
	logic [IW - 1:0]   free_idx;
	logic              hit_found;
	logic [IW - 1:0]   hit_idx;

	// 16-bit Fibonacci LFSR with taps 16 14 13 11
	always_ff @(posedge CLK) begin
		if (RESET)
			lfsr <= `LFSR_SEED;
		else if (game_tick)
			lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
	end

	assign kind_mod   = lfsr[11:8] % 4'd5;
	assign spawn_kind = enemy_kind_t'(kind_mod[2:0]);

	// Lowest free slot
	always_comb begin
		free_found = 1'b0;
		free_idx   = '0;
		for (int i = `ENEMY_SLOTS - 1; i >= 0; i--) begin
			if (!active[i]) begin
				free_found = 1'b1;
				free_idx   = IW'(i);
			end
		end
	end

	// Lowest active enemy on the probe's line and within its reach
	always_comb begin
		hit_found = 1'b0;
		hit_idx   = '0;
		for (int i = `ENEMY_SLOTS - 1; i >= 0; i--) begin
			if (active[i] && slot_angle[i] == probe_angle && slot_dist[i] <= probe_dist) begin
				hit_found = 1'b1;
				hit_idx   = IW'(i);
			end
		end
	end

	assign hit       = probe_valid & hit_found;
	assign kill      = hit & (hit_damage >= slot_health[hit_idx]);
	assign kill_kind = slot_kind[hit_idx];

	always_ff @(posedge CLK) begin
		if (RESET) begin
			active <= '0;
		end else begin
			if (spawn_en && free_found)
				active[free_idx] <= 1'b1;
			if (enemy_step) begin
				for (int i = 0; i < `ENEMY_SLOTS; i++) begin
					if (active[i] && slot_dist[i] < enemy_expiry(slot_kind[i]))
						active[i] <= 1'b0;           // Reached the ship
				end
			end
			if (kill)
				active[hit_idx] <= 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (spawn_en && free_found) begin
			slot_kind[free_idx]   <= spawn_kind;
			slot_angle[free_idx]  <= lfsr[3:0];
			slot_dist[free_idx]   <= dist_t'(`SPAWN_DIST);
			slot_health[free_idx] <= enemy_health(spawn_kind);
		end
		if (enemy_step) begin
			for (int i = 0; i < `ENEMY_SLOTS; i++) begin
				if (slot_dist[i] >= enemy_expiry(slot_kind[i]))
					slot_dist[i] <= slot_dist[i] - enemy_speed(slot_kind[i]);
			end
		end
		if (hit && !kill)
			slot_health[hit_idx] <= slot_health[hit_idx] - hit_damage;
	end

	always_comb begin
		enemy_count = '0;
		for (int i = 0; i < `ENEMY_SLOTS; i++)
			enemy_count = enemy_count + ($bits(enemy_count))'(active[i]);
	end

endmodule

`default_nettype wire

// File: design/bullet_table.sv
`timescale 1ns/100ps
`default_nettype none
`include "game_defs.svh"

module bullet_table import game_pkg::*; (
	input  logic       CLK,
	input  logic       RESET,
	input  logic       fire_en,
	input  weapon_t    weapon,
	input  angle_t     ship_angle,
	input  logic       sweep_en,
	input  logic [$clog2(`BULLET_SLOTS) - 1:0] bullet_index,
	input  logic       hit,                          // From the enemy search
	output logic       probe_valid,
	output angle_t     probe_angle,
	output dist_t      probe_dist,                   // Distance after this move
	output logic [3:0] hit_damage,
	output logic [$clog2(`BULLET_SLOTS + 1) - 1:0] bullet_count
);

	logic [`BULLET_SLOTS - 1:0] active;
	angle_t     slot_angle [`BULLET_SLOTS];
	dist_t      slot_dist  [`BULLET_SLOTS];
	weapon_t    slot_wpn   [`BULLET_SLOTS];
	logic [2:0] fan_n;
	logic [`BULLET_SLOTS - 1:0] fan_take;
	logic [2:0] fan_pos    [`BULLET_SLOTS];
	logic       cur_active;
	dist_t      cur_dist;
	weapon_t    cur_wpn;

	// Smaller fans use the tail of the five-bullet offsets
	function automatic angle_t fan_offset(logic [2:0] pos);
		case (pos)
			3'd0:    return 4'd2;
			3'd1:    return 4'd14;                       // -2
			3'd2:    return 4'd1;
			3'd3:    return 4'd15;                       // -1
			default: return 4'd0;
		endcase
	endfunction

	assign fan_n = fan_size(weapon);

	// Hand the fan out over the lowest free slots until they run out
	always_comb begin
		logic [2:0] placed;
		placed   = '0;
		fan_take = '0;
		for (int i = 0; i < `BULLET_SLOTS; i++) begin
			fan_pos[i] = '0;
			if (!active[i] && placed < fan_n) begin
				fan_take[i] = 1'b1;
				fan_pos[i]  = placed + (3'd5 - fan_n);
				placed      = placed + 3'd1;
			end
		end
	end

	assign cur_active = active[bullet_index];
	assign cur_dist   = slot_dist[bullet_index];
	assign cur_wpn    = slot_wpn[bullet_index];

	assign probe_valid = sweep_en & cur_active & (cur_dist < dist_t'(`BULLET_LIMIT));
	assign probe_angle = slot_angle[bullet_index];
	assign probe_dist  = cur_dist + bullet_speed(cur_wpn);
	assign hit_damage  = bullet_damage(cur_wpn);

	always_ff @(posedge CLK) begin
		if (RESET) begin
			active <= '0;
		end else begin
			if (fire_en)
				active <= active | fan_take;
			if (sweep_en && cur_active && (!probe_valid || hit))
				active[bullet_index] <= 1'b0;    // Out of range or spent on a hit
		end
	end

	always_ff @(posedge CLK) begin
		if (fire_en) begin
			for (int i = 0; i < `BULLET_SLOTS; i++) begin
				if (fan_take[i]) begin
					slot_angle[i] <= ship_angle + fan_offset(fan_pos[i]);
					slot_dist[i]  <= '0;
					slot_wpn[i]   <= weapon;
				end
			end
		end
		if (probe_valid)
			slot_dist[bullet_index] <= probe_dist;
	end

	always_comb begin
		bullet_count = '0;
		for (int i = 0; i < `BULLET_SLOTS; i++)
			bullet_count = bullet_count + ($bits(bullet_count))'(active[i]);
	end

endmodule

`default_nettype wire

// File: design/score_counter.sv
`timescale 1ns/100ps
`default_nettype none

module score_counter import game_pkg::*; (
	input  logic        CLK,
	input  logic        RESET,
	input  logic        kill,
	input  enemy_kind_t kill_kind,
	output score_t      score,
	output bcd_digits_t score_digits
);

	logic [3:0]  points;
	bcd_digits_t next_digits;

	assign points = kill_points(kill_kind);

	// Decimal add of a single-digit value rippling over the five digits
	always_comb begin
		logic [4:0] sum;
		logic [4:0] carry;
		carry = {1'b0, points};
		for (int d = 0; d < 5; d++) begin
			sum = {1'b0, score_digits[d]} + carry;
			if (sum > 5'd9) begin
				next_digits[d] = 4'(sum - 5'd10);
				carry          = 5'd1;
			end else begin
				next_digits[d] = sum[3:0];
				carry          = 5'd0;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (RESET) begin
			score        <= '0;
			score_digits <= '0;
		end else if (kill) begin
			score        <= score + score_t'(points);
			score_digits <= next_digits;           // Kept in step with the binary value
		end
	end

endmodule

`default_nettype wire

// File: design/shooter_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "game_defs.svh"

module shooter_top import game_pkg::*; (
	input  logic        CLK,
	input  logic        RESET,
	input  logic        game_tick,
	input  logic        weapon_switch,
	input  logic        fire,
	input  logic        rotate_cw,
	input  logic        rotate_ccw,
	output angle_t      ship_angle,
	output weapon_t     weapon,
	output logic        busy,
	output score_t      score,
	output bcd_digits_t score_digits,
	output logic [$clog2(`ENEMY_SLOTS + 1) - 1:0]  enemy_count,
	output logic [$clog2(`BULLET_SLOTS + 1) - 1:0] bullet_count
);

	logic        spawn_en;
	logic        fire_en;
	logic        enemy_step;
	logic        sweep_en;
	logic [$clog2(`BULLET_SLOTS) - 1:0] bullet_index;
	logic        probe_valid;
	angle_t      probe_angle;
	dist_t       probe_dist;
	logic [3:0]  hit_damage;
	logic        hit;
	logic        kill;
	enemy_kind_t kill_kind;

	game_control u_control (
		.CLK(CLK), .RESET(RESET), .game_tick(game_tick),
		.weapon_switch(weapon_switch), .fire(fire),
		.rotate_cw(rotate_cw), .rotate_ccw(rotate_ccw),
		.ship_angle(ship_angle), .weapon(weapon), .busy(busy),
		.spawn_en(spawn_en), .fire_en(fire_en), .enemy_step(enemy_step),
		.sweep_en(sweep_en), .bullet_index(bullet_index)
	);

	enemy_table u_enemies (
		.CLK(CLK), .RESET(RESET), .game_tick(game_tick),
		.spawn_en(spawn_en), .enemy_step(enemy_step),
		.probe_valid(probe_valid), .probe_angle(probe_angle),
		.probe_dist(probe_dist), .hit_damage(hit_damage),
		.hit(hit), .kill(kill), .kill_kind(kill_kind), .enemy_count(enemy_count)
	);

	bullet_table u_bullets (
		.CLK(CLK), .RESET(RESET), .fire_en(fire_en), .weapon(weapon),
		.ship_angle(ship_angle), .sweep_en(sweep_en), .bullet_index(bullet_index),
		.hit(hit), .probe_valid(probe_valid), .probe_angle(probe_angle),
		.probe_dist(probe_dist), .hit_damage(hit_damage), .bullet_count(bullet_count)
	);

	score_counter u_score (
		.CLK(CLK), .RESET(RESET), .kill(kill), .kill_kind(kill_kind),
		.score(score), .score_digits(score_digits)
	);

endmodule

`default_nettype wire

// File: tb/shooter_checker.sv
`timescale 1ns/100ps
`default_nettype none
`include "game_defs.svh"

module shooter_checker import game_pkg::*; (
	input logic    CLK,
	input logic    RESET,
	input logic    busy,
	input weapon_t weapon,
	input score_t  score,
	input logic [$clog2(`ENEMY_SLOTS + 1) - 1:0]  enemy_count,
	input logic [$clog2(`BULLET_SLOTS + 1) - 1:0] bullet_count
);

	enemy_bound: assert property (@(posedge CLK) disable iff (RESET)
		enemy_count <= `ENEMY_SLOTS)
		else $error("enemy_count %0d beyond the table size", enemy_count);

	bullet_bound: assert property (@(posedge CLK) disable iff (RESET)
		bullet_count <= `BULLET_SLOTS)
		else $error("bullet_count %0d beyond the table size", bullet_count);

	// Only three weapons exist
	weapon_legal: assert property (@(posedge CLK) disable iff (RESET)
		weapon != 2'd3)
		else $error("weapon holds the unused code 3");

	score_rising: assert property (@(posedge CLK) disable iff (RESET)
		score >= $past(score))
		else $error("score dropped from %0d to %0d", $past(score), score);

	idle_after_reset: assert property (@(posedge CLK)
		$fell(RESET) |-> !busy)
		else $error("busy high right after reset");

endmodule

bind shooter_top shooter_checker u_checker (
	.CLK(CLK), .RESET(RESET), .busy(busy), .weapon(weapon), .score(score),
	.enemy_count(enemy_count), .bullet_count(bullet_count)
);

`default_nettype wire

// File: tb/shooter_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "game_defs.svh"

module shooter_tb import game_pkg::*; ();

	localparam int WAIT_LIMIT = 100;              // Cycles allowed for any busy edge
	localparam int BTN_WPN  = 0;
	localparam int BTN_FIRE = 1;
	localparam int BTN_CW   = 2;
	localparam int BTN_CCW  = 3;

	logic        CLK;
	logic        RESET;
	logic        game_tick;
	logic        weapon_switch;
	logic        fire;
	logic        rotate_cw;
	logic        rotate_ccw;
	angle_t      ship_angle;
	weapon_t     weapon;
	logic        busy;
	score_t      score;
	bcd_digits_t score_digits;
	logic [$clog2(`ENEMY_SLOTS + 1) - 1:0]  enemy_count;
	logic [$clog2(`BULLET_SLOTS + 1) - 1:0] bullet_count;

	integer      seed;
	integer      fd;
	integer      code;
	integer      n_items;
	integer      arg;
	integer      expv;
	reg [1023:0] line;
	reg [127:0]  op;
	int          checks;
	int          errors;
	int          test_errors;
	int          test_id;
	int          tests_run;
	int          tests_failed;
	logic        timed_out;
	score_t      last_score;
	score_t      delta;

	shooter_top UUT (
		.CLK(CLK), .RESET(RESET), .game_tick(game_tick),
		.weapon_switch(weapon_switch), .fire(fire),
		.rotate_cw(rotate_cw), .rotate_ccw(rotate_ccw),
		.ship_angle(ship_angle), .weapon(weapon), .busy(busy),
		.score(score), .score_digits(score_digits),
		.enemy_count(enemy_count), .bullet_count(bullet_count)
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	// Decimal digits of a value with digit 0 in the low nibble
	function automatic logic [19:0] decimal_digits(input logic [31:0] value);
		logic [31:0] rest;
		logic [19:0] digits;
		rest   = value;
		digits = '0;
		for (int d = 0; d < 5; d++) begin
			digits[d * 4 +: 4] = 4'(rest % 10);
			rest = rest / 10;
		end
		return digits;
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			test_errors++;
			$display("error at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
		end
	endtask

	task automatic drive_button(input int which, input logic level);
		case (which)
			BTN_WPN:  weapon_switch <= level;
			BTN_FIRE: fire <= level;
			BTN_CW:   rotate_cw <= level;
			default:  rotate_ccw <= level;
		endcase
	endtask

	// Low for 2 cycles and then high for 4
	task automatic press_button(input int which, input int count);
		for (int i = 0; i < count; i++) begin
			@(posedge CLK);
			drive_button(which, 1'b0);
			repeat (2) @(posedge CLK);
			drive_button(which, 1'b1);
			repeat (4) @(posedge CLK);
		end
	endtask

	task automatic apply_reset;
		@(posedge CLK);
		RESET         <= 1'b1;
		game_tick     <= 1'b0;
		weapon_switch <= 1'b1;
		fire          <= 1'b1;
		rotate_cw     <= 1'b1;
		rotate_ccw    <= 1'b1;
		repeat (3) @(posedge CLK);
		RESET <= 1'b0;
		@(negedge CLK);
	endtask

	task automatic wait_busy(input logic level);
		int n;
		n = 0;
		@(negedge CLK);
		while (busy !== level && n < WAIT_LIMIT) begin
			@(negedge CLK);
			n++;
		end
		if (busy !== level) begin
			timed_out = 1'b1;
			$display("timeout at %0t: busy did not become %0d within %0d cycles",
				$time, level, WAIT_LIMIT);
		end
	endtask

	task automatic run_tick;
		@(posedge CLK);
		game_tick <= 1'b1;
		@(posedge CLK);
		game_tick <= 1'b0;
		wait_busy(1'b1);
		wait_busy(1'b0);
	endtask

	task automatic fire_and_tick(input int count);
		for (int i = 0; i < count && !timed_out; i++) begin
			press_button(BTN_FIRE, 1);
			run_tick();
		end
	endtask

	task automatic random_run(input int count);
		logic [31:0] r;
		score_t      start_score;
		start_score = score;
		for (int i = 0; i < count && !timed_out; i++) begin
			r = $random(seed);
			if (r[0])
				press_button(BTN_FIRE, 1);
			if (r[3:1] == 3'd0)
				press_button(BTN_CCW, 1);
			else if (r[3:1] == 3'd1)
				press_button(BTN_CW, 1);
			if (r[7:4] == 4'd0)
				press_button(BTN_WPN, 1);
			run_tick();
		end
		if (!timed_out && score == start_score) begin
			errors++;
			test_errors++;
			$display("random run of %0d ticks scored no kill at all", count);
		end
	endtask

	task automatic finish_test;
		if (test_id > 0) begin
			tests_run++;
			if (test_errors == 0) begin
				$display("test %0d done, no errors", test_id);
			end else begin
				tests_failed++;
				$display("test %0d done, %0d errors", test_id, test_errors);
			end
		end
		test_errors = 0;
	endtask

	// Every score step is one kill and the digits follow the binary value
	always @(negedge CLK) begin
		if (RESET) begin
			last_score = '0;
		end else if (score !== last_score) begin
			delta = score - last_score;
			if (delta != 2 && delta != 3 && delta != 5 && delta != 6 && delta != 9) begin
				errors++;
				test_errors++;
				$display("score at %0t moved by %0d, which no kill can give", $time, delta);
			end
			check_value("score_digits", score_digits, decimal_digits(score));
			last_score = score;
		end
	end

	initial begin
		RESET         = 1'b1;
		game_tick     = 1'b0;
		weapon_switch = 1'b1;
		fire          = 1'b1;
		rotate_cw     = 1'b1;
		rotate_ccw    = 1'b1;
		seed          = 32'h6433;
		checks        = 0;
		errors        = 0;
		test_errors   = 0;
		test_id       = 0;
		tests_run     = 0;
		tests_failed  = 0;
		timed_out     = 1'b0;
		apply_reset();
		fd = $fopen("tb/shooter_input.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open the stimulus file tb/shooter_input.txt");
		end else begin
			code = $fgets(line, fd);
			while (code != 0 && !timed_out) begin
				op      = '0;
				n_items = $sscanf(line, "%s %d %d", op, arg, expv);
				if (n_items == 3) begin
					case (op)
						"test": begin
							finish_test();
							test_id = arg;
						end
						"reset":     apply_reset();
						"weapon":    press_button(BTN_WPN, arg);
						"fire":      press_button(BTN_FIRE, arg);
						"cw":        press_button(BTN_CW, arg);
						"ccw":       press_button(BTN_CCW, arg);
						"tick":      repeat (arg) run_tick();
						"fire_tick": fire_and_tick(arg);
						"random":    random_run(arg);
						"chk_angle": begin
							@(negedge CLK);
							check_value("ship_angle", ship_angle, expv);
						end
						"chk_weapon": begin
							@(negedge CLK);
							check_value("weapon", weapon, expv);
						end
						"chk_score": begin
							@(negedge CLK);
							check_value("score", score, expv);
							check_value("score_digits", score_digits, decimal_digits(expv));
						end
						"chk_enemies": begin
							@(negedge CLK);
							check_value("enemy_count", enemy_count, expv);
						end
						"chk_bullets": begin
							@(negedge CLK);
							check_value("bullet_count", bullet_count, expv);
						end
						"chk_busy": begin
							@(negedge CLK);
							check_value("busy", busy, expv);
						end
						default: begin
							errors++;
							test_errors++;
							$display("unknown command in the stimulus file: %0s", op);
						end
					endcase
				end
				code = $fgets(line, fd);
			end
			$fclose(fd);
		end
		finish_test();
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0 && !timed_out && tests_run > 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/shooter_input.txt
# columns: opcode argument expected; argument counts presses or ticks, expected is for chk_ lines
# ops: test reset weapon fire cw ccw tick fire_tick random chk_angle chk_weapon chk_score ...
test 1 0
reset 0 0
chk_angle 0 0
chk_weapon 0 0
chk_score 0 0
chk_enemies 0 0
chk_bullets 0 0
chk_busy 0 0
test 2 0
weapon 1 0
chk_weapon 0 1
weapon 1 0
chk_weapon 0 2
weapon 1 0
chk_weapon 0 0
test 3 0
ccw 3 0
chk_angle 0 3
cw 5 0
chk_angle 0 14
test 4 0
reset 0 0
fire_tick 1 0
chk_bullets 0 5
chk_enemies 0 1
reset 0 0
weapon 1 0
fire_tick 1 0
chk_bullets 0 3
chk_enemies 0 1
reset 0 0
weapon 2 0
fire_tick 1 0
chk_bullets 0 1
chk_enemies 0 1
test 5 0
reset 0 0
tick 8 0
chk_enemies 0 8
tick 2 0
chk_enemies 0 8
chk_bullets 0 0
chk_score 0 0
test 6 0
reset 0 0
random 150 0
chk_busy 0 0

// File: shooter.f
+incdir+design
design/game_pkg.sv
design/game_control.sv
design/enemy_table.sv
design/bullet_table.sv
design/score_counter.sv
design/shooter_top.sv
tb/shooter_checker.sv
tb/shooter_tb.sv
